/* rtl/ahci_tx_pkg.sv */
// AHCI transmit package
// constants and struct types shared by the command fetch, command FIS and
// data FIS transmit blocks
`default_nettype none

package ahci_tx_pkg;

    localparam logic [9:0]  clb_offs32 = 10'h200; // command list base, dword address
    localparam logic [31:0] data_fis   = 32'h46;  // H2D data FIS header dword

    localparam int reg_addr_w = 10;  // register memory address bits
    localparam int ct_addr_w  = 5;   // command table dword address bits
    localparam int reg_rd_lat = 2;   // reg_re -> reg_rdata
    localparam int ct_rd_lat  = 1;   // ct_re -> ct_data
    localparam int dx_max_dw  = 512; // longest data FIS payload
    localparam int dw_cnt_w   = 10;

    // dword 0 of the command header, ATAPI bit not kept
    typedef struct packed {
        logic [15:0] prdtl; // PRD table length in entries
        logic        c;     // clear busy on R_OK
        logic        b;     // BIST
        logic        r;     // reset
        logic        p;     // prefetchable
        logic        w;     // write, memory -> device
        logic [4:0]  cfl;   // command FIS length in dwords
    } chead_t;

    // one dword toward the transmit FIFO
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  kind; // [0] first dword of FIS, [1] last
    } todev_word_t;

    typedef struct packed {
        logic xmit_err; // bit 1
        logic syncesc;  // bit 0
    } tx_err_t;

endpackage

`default_nettype wire

/* rtl/chead_fetch.sv */
// command header fetch
// reads the 3-dword header at the command list base, decodes dword 0 and
// pulses the DMA engine to load the table address and start
`default_nettype none

module chead_fetch import ahci_tx_pkg::*; (
    input  wire                   mclk,
    input  wire                   hba_rst,
    input  wire                   fetch_cmd,
    input  wire                   clear_cmd_to_issue,
    input  wire  [31:0]           reg_rdata,
    output logic [reg_addr_w-1:0] reg_addr,
    output logic                  reg_re,
    output chead_t                chead,
    output logic                  dma_ctba_ld,
    output logic                  dma_start,
    output logic                  cmd_to_issue,
    output logic                  fetch_cmd_busy,
    output logic                  fetch_end
);

    logic [2:0]            rd_sh;  // running one, a bit per header dword
    logic [reg_rd_lat+2:0] stb_sh; // first read, delayed by memory latency, then DMA pulses
    logic                  cap;

    assign reg_re      = |rd_sh;
    assign cap         = stb_sh[reg_rd_lat-1]; // dword 0 is on reg_rdata
    assign dma_ctba_ld = stb_sh[reg_rd_lat+1]; // two cycles after capture
    assign dma_start   = stb_sh[reg_rd_lat+2];
    assign fetch_end   = stb_sh[reg_rd_lat+2]; // header done together with start

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            rd_sh  <= '0;
            stb_sh <= '0;
        end else begin
            rd_sh  <= {rd_sh[1:0], fetch_cmd};
            stb_sh <= (reg_rd_lat + 3)'({stb_sh, rd_sh[0]});
        end
    end

    // address walks 0x200..0x202 while reading
    always_ff @(posedge mclk) begin
        if (fetch_cmd)   reg_addr <= clb_offs32;
        else if (reg_re) reg_addr <= reg_addr + 1'b1;
    end

    // decode dword 0, bit 5 (ATAPI) unused
    always_ff @(posedge mclk) begin
        if (cap) begin
            chead.prdtl <= reg_rdata[31:16];
            chead.c     <= reg_rdata[10];
            chead.b     <= reg_rdata[9];
            chead.r     <= reg_rdata[8];
            chead.p     <= reg_rdata[7];
            chead.w     <= reg_rdata[6];
            chead.cfl   <= reg_rdata[4:0];
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst)                 cmd_to_issue <= 1'b0;
        else if (fetch_end)          cmd_to_issue <= 1'b1; // set wins over a same-cycle clear
        else if (clear_cmd_to_issue) cmd_to_issue <= 1'b0;

        if (hba_rst)                 fetch_cmd_busy <= 1'b0;
        else if (fetch_cmd)          fetch_cmd_busy <= 1'b1;
        else if (fetch_end)          fetch_cmd_busy <= 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/cfis_sender.sv */
// command FIS sender
// reads cfl dwords from the command table and hands them on as FIS words,
// marking first and last, read strobes throttled by FIFO room
`default_nettype none

module cfis_sender import ahci_tx_pkg::*; (
    input  wire                  mclk,
    input  wire                  hba_rst,
    input  wire                  cfis_xmit,
    input  wire                  hold,        // header fetch or table read still busy
    input  wire  [4:0]           cfl,
    input  wire                  todev_ready,
    input  wire  [31:0]          ct_data,
    output logic [ct_addr_w-1:0] ct_addr,
    output logic                 ct_re,
    output todev_word_t          word,
    output logic                 word_wr,
    output logic                 cfis_end
);

    logic                 pend;     // cfis_xmit seen, waiting for hold to drop
    logic                 start;
    logic [4:0]           left_rd;  // dwords still to be read
    logic [4:0]           left_out; // dwords still to come out of the table
    logic [ct_rd_lat-1:0] ct_sh;    // read strobes in flight
    logic                 first;

    assign start    = pend && !hold;
    assign ct_re    = todev_ready && (left_rd != '0);
    assign word_wr  = ct_sh[ct_rd_lat-1]; // table data valid now
    assign cfis_end = word_wr && (left_out == 5'd1);

    always_comb begin
        word.data = ct_data;
        word.kind = {left_out == 5'd1, first};
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            pend     <= 1'b0;
            left_rd  <= '0;
            left_out <= '0;
            ct_sh    <= '0;
            first    <= 1'b0;
        end else begin
            if (cfis_xmit)  pend <= 1'b1;
            else if (start) pend <= 1'b0;

            if (start)      left_rd <= cfl;
            else if (ct_re) left_rd <= left_rd - 1'b1;

            if (start)        left_out <= cfl; // output side trails by ct_rd_lat
            else if (word_wr) left_out <= left_out - 1'b1;

            if (start)        first <= 1'b1;
            else if (word_wr) first <= 1'b0;

            ct_sh <= ct_rd_lat'({ct_sh, ct_re});
        end
    end

    always_ff @(posedge mclk) begin
        if (start)      ct_addr <= '0;
        else if (ct_re) ct_addr <= ct_addr + 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/dx_sender.sv */
// data FIS sender
// writes the 0x46 header then forwards DMA dwords, at most dx_max_dw or
// the transfer counter; a transmit error ends the transfer
`default_nettype none

module dx_sender import ahci_tx_pkg::*; (
    input  wire                 mclk,
    input  wire                 hba_rst,
    input  wire                 dx_transmit,
    input  wire                 cmd_start,   // any command pulse, clears errors
    input  wire  [29:0]         xfer_cntr,   // dwords
    input  wire                 dma_dav,
    input  wire  [31:0]         dma_out,
    input  wire                 todev_ready,
    input  wire                 syncesc_recv,
    input  wire                 xmit_err,
    output logic                dma_re,
    output todev_word_t         word,
    output logic                word_wr,
    output logic                hdr_sent,
    output logic [dw_cnt_w-1:0] dwords_sent,
    output tx_err_t             dx_err,
    output logic                dx_end
);

    logic                pend;   // header not yet written
    logic                en;     // forwarding DMA data
    logic                active;
    logic [dw_cnt_w-1:0] left;
    logic                no_data;
    logic                dma_last;

    assign no_data  = (left == '0);
    assign hdr_sent = pend && todev_ready && !(|dx_err);
    assign dma_re   = en && dma_dav && todev_ready && !(|dx_err);
    assign dma_last = dma_re && (left == dw_cnt_w'(1));
    assign word_wr  = hdr_sent || dma_re;
    assign dx_end   = dma_last || (hdr_sent && no_data) || (active && (|dx_err));

    always_comb begin
        if (en) begin
            word.data = dma_out;
            word.kind = {dma_last, 1'b0};
        end else begin
            word.data = data_fis;
            word.kind = {no_data, 1'b1}; // empty transfer, header is also last
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            pend   <= 1'b0;
            en     <= 1'b0;
            active <= 1'b0;
        end else begin
            if (dx_transmit)                pend <= 1'b1;
            else if (hdr_sent || dx_end)    pend <= 1'b0;

            if (dx_end)                     en <= 1'b0;
            else if (hdr_sent && !no_data)  en <= 1'b1;

            if (dx_transmit)                active <= 1'b1;
            else if (dx_end)                active <= 1'b0;
        end
    end

    // clip the transfer counter to one FIS
    always_ff @(posedge mclk) begin
        if (dx_transmit)
            left <= (xfer_cntr > 30'(dx_max_dw)) ? dw_cnt_w'(dx_max_dw)
                                                 : xfer_cntr[dw_cnt_w-1:0];
        else if (dma_re)
            left <= left - 1'b1;

        if (dx_transmit) dwords_sent <= '0;
        else if (dma_re) dwords_sent <= dwords_sent + 1'b1; // payload only
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || cmd_start) begin
            dx_err <= '0;
        end else begin
            if (syncesc_recv) dx_err.syncesc  <= 1'b1;
            if (xmit_err)     dx_err.xmit_err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/todev_mux.sv */
// FIFO write register
// takes the word of whichever sender writes and presents it for one cycle
`default_nettype none

module todev_mux import ahci_tx_pkg::*; (
    input  wire               mclk,
    input  wire               hba_rst,
    input  wire  todev_word_t cfis_word,
    input  wire               cfis_wr,
    input  wire  todev_word_t dx_word,
    input  wire               dx_wr,
    output todev_word_t       todev,
    output logic              todev_valid
);

    // senders never write together, cfis checked first
    always_ff @(posedge mclk) begin
        if (cfis_wr)    todev <= cfis_word;
        else if (dx_wr) todev <= dx_word;   // otherwise hold
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) todev_valid <= 1'b0;
        else         todev_valid <= cfis_wr || dx_wr; // single write strobe
    end

endmodule

`default_nettype wire

/* rtl/ahci_fis_transmit.sv */
// AHCI port transmit
// fetches the command header, sends the command FIS and data FISes to the
// transport FIFO, and produces the combined done/busy and PRD start
`default_nettype none

module ahci_fis_transmit import ahci_tx_pkg::*; (
    input  wire                   mclk,
    input  wire                   hba_rst,
    input  wire                   fetch_cmd,
    input  wire                   cfis_xmit,
    input  wire                   dx_transmit,
    input  wire                   clear_cmd_to_issue,
    input  wire                   syncesc_recv,
    input  wire                   xmit_err,
    output logic [reg_addr_w-1:0] reg_addr,
    output logic                  reg_re,
    input  wire  [31:0]           reg_rdata,
    output logic [ct_addr_w-1:0]  ct_addr,
    output logic                  ct_re,
    input  wire  [31:0]           ct_data,
    input  wire  [29:0]           xfer_cntr,
    output logic                  dma_ctba_ld,
    output logic                  dma_start,
    output logic                  dma_dev_wr,
    output logic                  dma_prd_start,
    output logic                  dma_re,
    input  wire                   dma_ct_busy,
    input  wire                   dma_dav,
    input  wire  [31:0]           dma_out,
    output todev_word_t           todev,
    output logic                  todev_valid,
    input  wire                   todev_ready,  // room for at least four dwords
    output chead_t                chead,
    output logic                  cmd_to_issue,
    output logic                  fetch_cmd_busy,
    output logic                  done,
    output logic                  busy,
    output tx_err_t               dx_err,
    output logic [dw_cnt_w-1:0]   dwords_sent
);

    logic        fetch_end;
    logic        cfis_end;
    logic        dx_end;
    logic        hdr_sent;
    logic        cfis_wr;
    logic        dx_wr;
    todev_word_t cfis_word;
    todev_word_t dx_word;
    logic        any_cmd;
    logic        done_w;

    assign any_cmd    = fetch_cmd || cfis_xmit || dx_transmit;
    assign done_w     = fetch_end || cfis_end || dx_end;
    assign dma_dev_wr = chead.w;

    chead_fetch chead_fetch_i (
        .mclk, .hba_rst, .fetch_cmd, .clear_cmd_to_issue, .reg_rdata,
        .reg_addr, .reg_re, .chead, .dma_ctba_ld, .dma_start,
        .cmd_to_issue, .fetch_cmd_busy, .fetch_end
    );

    cfis_sender cfis_sender_i (
        .mclk, .hba_rst, .cfis_xmit,
        .hold     (fetch_cmd_busy || dma_ct_busy), // table must be in place
        .cfl      (chead.cfl),
        .todev_ready, .ct_data, .ct_addr, .ct_re,
        .word     (cfis_word),
        .word_wr  (cfis_wr),
        .cfis_end
    );

    dx_sender dx_sender_i (
        .mclk, .hba_rst, .dx_transmit,
        .cmd_start (any_cmd),
        .xfer_cntr, .dma_dav, .dma_out, .todev_ready, .syncesc_recv, .xmit_err,
        .dma_re,
        .word      (dx_word),
        .word_wr   (dx_wr),
        .hdr_sent, .dwords_sent, .dx_err, .dx_end
    );

    todev_mux todev_mux_i (
        .mclk, .hba_rst, .cfis_word, .cfis_wr, .dx_word, .dx_wr,
        .todev, .todev_valid
    );

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            done          <= 1'b0;
            busy          <= 1'b0;
            dma_prd_start <= 1'b0;
        end else begin
            done <= done_w;
            if (any_cmd)     busy <= 1'b1;
            else if (done_w) busy <= 1'b0; // falls as done rises
            // device reads may fetch PRDs early, writes wait for the data FIS
            dma_prd_start <= (dma_start && (chead.p || !chead.w)) || hdr_sent;
        end
    end

endmodule

`default_nettype wire

/* dv/ahci_fis_transmit_chk.sv */
// protocol checker for the AHCI port transmit
// FIFO write rules, DMA load/start order and the done pulse
`default_nettype none

module ahci_fis_transmit_chk import ahci_tx_pkg::*; (
    input wire mclk,
    input wire hba_rst,
    input wire todev_valid,
    input wire todev_ready,
    input wire cfis_wr,
    input wire dx_wr,
    input wire dma_ctba_ld,
    input wire dma_start,
    input wire done
);

    int fails = 0; // assertion failure count

    // each FIFO write goes back to a word started while the FIFO had room
    // data FIS words start in their strobe cycle, table reads ct_rd_lat earlier
    a_ready: assert property (@(posedge mclk) disable iff (hba_rst)
        todev_valid |-> ($past(dx_wr) && $past(todev_ready))
                     || ($past(cfis_wr) && $past(todev_ready, ct_rd_lat + 1)))
        else begin
            $error("FIFO word started while todev_ready low");
            fails++;
        end

    a_ld_start: assert property (@(posedge mclk) disable iff (hba_rst)
        dma_ctba_ld |=> dma_start)
        else begin
            $error("dma_start did not follow dma_ctba_ld");
            fails++;
        end

    a_done_pulse: assert property (@(posedge mclk) disable iff (hba_rst)
        done |=> !done)
        else begin
            $error("done longer than one cycle");
            fails++;
        end

endmodule

bind ahci_fis_transmit ahci_fis_transmit_chk chk_i (.*);

`default_nettype wire

/* dv/ahci_fis_transmit_tb.sv */
// testbench for the AHCI port transmit
// random headers, command tables and DMA data checked against a model of
// the fetch timing, FIS framing, clipping and error rules
`default_nettype none

module ahci_fis_transmit_tb import ahci_tx_pkg::*; ();

    logic                  mclk = 1'b0;
    logic                  hba_rst;
    logic                  fetch_cmd, cfis_xmit, dx_transmit, clear_cmd_to_issue;
    logic                  syncesc_recv, xmit_err;
    logic [reg_addr_w-1:0] reg_addr;
    logic                  reg_re;
    logic [31:0]           reg_rdata;
    logic [ct_addr_w-1:0]  ct_addr;
    logic                  ct_re;
    logic [31:0]           ct_data;
    logic [29:0]           xfer_cntr;
    logic                  dma_ctba_ld, dma_start, dma_dev_wr, dma_prd_start, dma_re;
    logic                  dma_ct_busy, dma_dav;
    logic [31:0]           dma_out;
    todev_word_t           todev;
    logic                  todev_valid, todev_ready;
    chead_t                chead;
    logic                  cmd_to_issue, fetch_cmd_busy, done, busy;
    tx_err_t               dx_err;
    logic [dw_cnt_w-1:0]   dwords_sent;

    integer                  seed = 32'h017fe530;
    logic [31:0]             reg_mem [1024];
    logic [31:0]             ct_mem [32];
    logic [reg_rd_lat*32-1:0] reg_pipe;    // read data in flight with the newest at the bottom
    todev_word_t             fifo_q [$];   // every word the FIFO took
    int                      dma_idx;      // next DMA pattern index
    int                      ct_busy_left;
    int                      prd_cnt;

    always #4 mclk = ~mclk;

    ahci_fis_transmit dut_i (.*);

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] dma_word(input int i);
        return {16'hd5a0 ^ i[15:0], i[15:0]};
    endfunction

    // AHCI command header dword 0 layout
    function automatic chead_t decode(input logic [31:0] d);
        chead_t h;
        h.prdtl = d[31:16];
        h.c     = d[10];
        h.b     = d[9];
        h.r     = d[8];
        h.p     = d[7];
        h.w     = d[6];
        h.cfl   = d[4:0];
        return h;
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopped on %s", what);
        end
    endtask

    always @(negedge mclk) begin
        if (dut_i.chk_i.fails != 0) begin
            $display("a protocol assertion failed at time %0t", $time);
            $display("test failed");
            $fatal(1, "protocol assertion");
        end
    end

    // register memory with a fixed read latency
    assign reg_rdata = reg_pipe[reg_rd_lat*32-1 -: 32];

    always @(posedge mclk) begin
        reg_pipe <= (reg_rd_lat*32)'({reg_pipe, reg_re ? reg_mem[reg_addr] : 32'h0});
        if (ct_re) ct_data <= ct_mem[ct_addr];       // one cycle table latency
        todev_ready <= (rnd(4) != 0);
        dma_dav     <= (rnd(4) != 0);
        if (dma_re) begin
            dma_idx <= dma_idx + 1;
            dma_out <= dma_word(dma_idx + 1);
        end
        if (dma_start) begin                         // table fetch keeps DMA busy a while
            dma_ct_busy  <= 1'b1;
            ct_busy_left <= rnd(6);
        end else if (ct_busy_left != 0) begin
            ct_busy_left <= ct_busy_left - 1;
        end else begin
            dma_ct_busy <= 1'b0;
        end
        if (todev_valid) fifo_q.push_back(todev);
        if (dma_prd_start) prd_cnt <= prd_cnt + 1;
    end

    task automatic pulse_cmd(input int which);
        @(posedge mclk);
        case (which)
            0:       fetch_cmd <= 1'b1;
            1:       cfis_xmit <= 1'b1;
            2:       dx_transmit <= 1'b1;
            default: clear_cmd_to_issue <= 1'b1;
        endcase
        @(posedge mclk);
        fetch_cmd          <= 1'b0;
        cfis_xmit          <= 1'b0;
        dx_transmit        <= 1'b0;
        clear_cmd_to_issue <= 1'b0;
    endtask

    // busy must hold until done
    // an optional error pulse goes out on cycle err_at
    task automatic wait_done(input int limit, input int err_at, input int err_sel,
                             input string what);
        int n;
        n = 0;
        forever begin
            @(negedge mclk);
            if (done) break;
            compare(busy, 1, "busy before done");
            n++;
            if (n > limit) begin
                $display("timeout: %s never arrived", what);
                $display("test failed");
                $fatal(1, "timeout");
            end
            @(posedge mclk);
            syncesc_recv <= (n == err_at) && (err_sel == 0);
            xmit_err     <= (n == err_at) && (err_sel == 1);
        end
        compare(busy, 0, "busy with done");
    endtask

    task automatic fetch_header(input logic [31:0] dw0);
        chead_t exp;
        int     t;
        exp = decode(dw0);
        reg_mem[clb_offs32] = dw0;
        pulse_cmd(0);
        for (t = 1; t <= 7; t++) begin               // fixed fetch schedule
            @(negedge mclk);
            compare(reg_re, t <= 3, "reg_re");
            if (t <= 3) compare(reg_addr, clb_offs32 + t - 1, "reg_addr");
            compare(dma_ctba_ld, t == 5, "dma_ctba_ld");
            compare(dma_start, t == 6, "dma_start");
            compare(dma_prd_start, (t == 7) && (exp.p || !exp.w), "dma_prd_start on dma_start");
            compare(done, t == 7, "done after fetch");
            compare(busy, t < 7, "busy during fetch");
            compare(fetch_cmd_busy, t < 7, "fetch_cmd_busy");
            if (t == 1) compare(dx_err, 2'b00, "dx_err after new command");
        end
        compare(chead, exp, "chead");
        compare(cmd_to_issue, 1, "cmd_to_issue after fetch");
        compare(dma_dev_wr, exp.w, "dma_dev_wr");
        pulse_cmd(3);
        @(negedge mclk);
        compare(cmd_to_issue, 0, "cmd_to_issue after clear");
    endtask

    task automatic send_cfis(input int cfl);
        todev_word_t w;
        int          i;
        fifo_q.delete();
        pulse_cmd(1);                                // may wait on dma_ct_busy
        wait_done(300, -1, 0, "command FIS done");
        @(negedge mclk);                             // last word lands in the FIFO
        compare(fifo_q.size(), cfl, "command FIS length");
        for (i = 0; i < cfl; i++) begin
            w = fifo_q[i];
            compare(w.data, ct_mem[i], "command FIS dword");
            compare(w.kind, {i == cfl - 1, i == 0}, "command FIS first/last");
        end
    endtask

    task automatic send_data(input int cnt, input int err_at, input int err_sel);
        todev_word_t w;
        int          n, base, prd0, i, paid;
        n    = (cnt > dx_max_dw) ? dx_max_dw : cnt;  // one FIS at most
        base = dma_idx;
        prd0 = prd_cnt;
        fifo_q.delete();
        @(posedge mclk);
        xfer_cntr <= cnt[29:0];
        pulse_cmd(2);
        wait_done(5000, err_at, err_sel, "data FIS done");
        @(negedge mclk);
        paid = (fifo_q.size() > 0) ? fifo_q.size() - 1 : 0;
        if (err_at < 0) begin
            compare(fifo_q.size(), n + 1, "data FIS length");
            compare(dx_err, 2'b00, "dx_err without error");
        end else begin
            compare(dx_err, (err_sel == 0) ? 2'b01 : 2'b10, "dx_err after error");
            compare(dma_re, 0, "dma_re after error");
        end
        compare(dwords_sent, paid, "dwords_sent");
        compare(prd_cnt - prd0, fifo_q.size() > 0, "dma_prd_start on header");
        for (i = 0; i < fifo_q.size(); i++) begin
            w = fifo_q[i];
            if (i == 0) begin
                compare(w.data, data_fis, "data FIS header");
                compare(w.kind, {(n == 0) && (err_at < 0), 1'b1}, "header kind");
            end else begin
                compare(w.data, dma_word(base + i - 1), "data FIS payload");
                compare(w.kind, {(err_at < 0) && (i == n), 1'b0}, "payload kind");
            end
        end
    endtask

    function automatic int pick_count();
        case (rnd(4))
            0:       return rnd(8);                  // includes the empty transfer
            1:       return rnd(600);
            2:       return 512 + rnd(1 << 20);      // clipped
            default: return 1 + rnd(64);
        endcase
    endfunction

    initial begin
        logic [31:0] dw0;
        int          iter, i, cfl;
        hba_rst = 1'b1;
        fetch_cmd = 1'b0;
        cfis_xmit = 1'b0;
        dx_transmit = 1'b0;
        clear_cmd_to_issue = 1'b0;
        syncesc_recv = 1'b0;
        xmit_err = 1'b0;
        ct_data = 32'h0;
        xfer_cntr = 30'h0;
        dma_ct_busy = 1'b0;
        dma_dav = 1'b0;
        todev_ready = 1'b0;
        reg_pipe = '0;
        dma_idx = 0;
        dma_out = dma_word(0);
        ct_busy_left = 0;
        prd_cnt = 0;
        for (i = 0; i < 1024; i++) reg_mem[i] = {6'h2b, i[9:0], 6'h15, ~i[9:0]};
        repeat (9) @(posedge mclk);
        @(negedge mclk);
        compare({todev_valid, reg_re, ct_re, dma_re, done, busy, fetch_cmd_busy,
                 cmd_to_issue, dma_ctba_ld, dma_start, dma_prd_start}, 0,
                "control outputs in reset");
        @(posedge mclk);
        hba_rst <= 1'b0;
        for (iter = 0; iter < 12; iter++) begin
            dw0 = $random(seed);
            cfl = 2 + rnd(15);
            dw0[4:0] = cfl[4:0];
            for (i = 0; i < 32; i++) ct_mem[i] = $random(seed);
            fetch_header(dw0);
            send_cfis(cfl);
            send_data(pick_count(), -1, 0);
            if (iter % 3 == 2) send_data(200 + rnd(200), 2 + rnd(30), rnd(2));
        end
        repeat (4) @(negedge mclk);
        if (dut_i.chk_i.fails == 0) begin
            $display("test passed");
        end else begin
            $display("protocol assertions failed %0d times", dut_i.chk_i.fails);
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/ahci_tx_pkg.sv
rtl/chead_fetch.sv
rtl/cfis_sender.sv
rtl/dx_sender.sv
rtl/todev_mux.sv
rtl/ahci_fis_transmit.sv
dv/ahci_fis_transmit_chk.sv
dv/ahci_fis_transmit_tb.sv
